// File: tb.f
+incdir+source
source/svc_pkg.sv
source/svc_cmd_decode.sv
source/svc_override_regs.sv
source/svc_reset_seq.sv
source/svc_signal_mux.sv
source/svc_top.sv
sim/svc_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Compile and run the testbench with Verilator, then scan the log
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --timescale 1ns/1ns \
  -f tb.f --top-module svc_tb -o svc_sim

./obj_dir/svc_sim | tee sim.log

if grep -q "Something failed" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi

echo "simulation finished without failures"
exit 0

// File: sim/svc_tb.sv
// Self-checking table-driven testbench for the service override block
`timescale 1ns/1ns
`default_nettype none
`include "svc_defs.svh"

module svc_tb;
  import svc_pkg::*;

  // Second command code of zero means the entry sends only one command
  localparam svc_cmd_t CMD_NONE = 8'h00;
  localparam int HOLD_TIMEOUT = 40;

  typedef struct {
    string    name;
    svc_cmd_t cmd;
    svc_cmd_t cmd2;
    awuser_t  aw_val;
    logic     strobe;
    logic     aw_en;
    logic     zero_en;
    logic     zero_lvl;
    logic     tok_en;
    logic     ppd_en;
    logic     hold;
  } test_t;

  logic      clk;
  logic      cptra_rst_b;
  logic      svc_cmd_valid_i;
  svc_cmd_t  svc_cmd_i;
  awuser_t   awuser_i, awuser_o;
  logic      fips_zero_ppd_i, fips_zero_ppd_o;
  rom_mask_t rom_zero_mask_i, rom_zero_mask_o;
  logic      lcc_scrap_mode_i, lcc_scrap_mode_o;
  logic      allow_rma_scrap_ppd_i, allow_rma_scrap_ppd_o;
  lc_token_t test_unlock_token_i, test_unlock_token_o;
  lc_token_t test_exit_dev_token_i, test_exit_dev_token_o;
  lc_token_t dev_exit_prod_token_i, dev_exit_prod_token_o;
  lc_token_t prod_exit_prodend_token_i, prod_exit_prodend_token_o;
  lc_token_t rma_token_i, rma_token_o;
  lc_tx_t    test_tokens_valid_i, test_tokens_valid_o;
  lc_tx_t    rma_token_valid_i, rma_token_valid_o;
  logic      fc_lcc_rst_ni_i, fc_lcc_rst_no;

  test_t       tests[$];
  logic [31:0] rng;
  logic        test_ok;
  logic        timed_out;
  int          pass_cnt;
  int          fail_cnt;
  int          low_total;
  int          start_total;

  svc_top DUT (.*);

  always #50 clk = ~clk;

  // Running count of rising edges that see the controller reset low
  always @(posedge clk) begin
    if (!fc_lcc_rst_no) begin
      low_total = low_total + 1;
    end
  end

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  // Flags are {strobe, aw_en, zero_en, zero_lvl, tok_en, ppd_en, hold}
  task automatic add_test(input string name, input svc_cmd_t cmd, input svc_cmd_t cmd2,
                          input awuser_t aw_val, input logic [6:0] flags);
    test_t t;
    t.name     = name;
    t.cmd      = cmd;
    t.cmd2     = cmd2;
    t.aw_val   = aw_val;
    {t.strobe, t.aw_en, t.zero_en, t.zero_lvl, t.tok_en, t.ppd_en, t.hold} = flags;
    tests.push_back(t);
  endtask

  // The functional reset stays high when the entry measures the hold length
  task automatic draw_inputs(input logic hold);
    logic [31:0] r;
    r                         = next_rand();
    fips_zero_ppd_i           = r[0];
    lcc_scrap_mode_i          = r[1];
    allow_rma_scrap_ppd_i     = r[2];
    fc_lcc_rst_ni_i           = hold | r[3];
    test_tokens_valid_i       = r[7:4];
    rma_token_valid_i         = r[11:8];
    awuser_i                  = next_rand();
    rom_zero_mask_i           = next_rand();
    test_unlock_token_i       = {next_rand(), next_rand(), next_rand(), next_rand()};
    test_exit_dev_token_i     = {next_rand(), next_rand(), next_rand(), next_rand()};
    dev_exit_prod_token_i     = {next_rand(), next_rand(), next_rand(), next_rand()};
    prod_exit_prodend_token_i = {next_rand(), next_rand(), next_rand(), next_rand()};
    rma_token_i               = {next_rand(), next_rand(), next_rand(), next_rand()};
  endtask

  task automatic check_val(input string name, input string sig,
                           input logic [127:0] exp, input logic [127:0] act);
    assert (exp === act) else begin
      $display("error %s %s: expected %0h actual %0h", name, sig, exp, act);
      test_ok = 1'b0;
    end
  endtask

  // Ends two rising edges after the last command was sampled
  task automatic send_cmd(input test_t t);
    if (t.strobe) begin
      svc_cmd_valid_i = 1'b1;
      svc_cmd_i       = t.cmd;
      @(negedge clk);
      if (t.cmd2 != CMD_NONE) begin
        svc_cmd_i = t.cmd2;
        @(negedge clk);
      end
      svc_cmd_valid_i = 1'b0;
      @(negedge clk);
    end else begin
      repeat (2) @(negedge clk);
    end
  endtask

  task automatic check_outputs(input test_t t);
    logic      exp_ppd;
    logic      exp_scrap;
    rom_mask_t exp_mask;
    // Zeroization pattern is all ones with scrap low, the reset pattern the reverse
    if (!t.zero_en) begin
      exp_ppd   = fips_zero_ppd_i;
      exp_mask  = rom_zero_mask_i;
      exp_scrap = lcc_scrap_mode_i;
    end else if (t.zero_lvl) begin
      exp_ppd   = 1'b1;
      exp_mask  = `SVC_ZERO_MASK_ALL;
      exp_scrap = 1'b0;
    end else begin
      exp_ppd   = 1'b0;
      exp_mask  = 32'h0;
      exp_scrap = 1'b1;
    end
    check_val(t.name, "awuser", 128'(t.aw_en ? t.aw_val : awuser_i), 128'(awuser_o));
    check_val(t.name, "fips_zero_ppd", 128'(exp_ppd), 128'(fips_zero_ppd_o));
    check_val(t.name, "rom_zero_mask", 128'(exp_mask), 128'(rom_zero_mask_o));
    check_val(t.name, "lcc_scrap_mode", 128'(exp_scrap), 128'(lcc_scrap_mode_o));
    check_val(t.name, "allow_rma_scrap_ppd", 128'(t.ppd_en | allow_rma_scrap_ppd_i),
              128'(allow_rma_scrap_ppd_o));
    check_val(t.name, "test_unlock_token",
              t.tok_en ? `SVC_TOK_TEST_UNLOCK : test_unlock_token_i, test_unlock_token_o);
    check_val(t.name, "test_exit_dev_token",
              t.tok_en ? `SVC_TOK_TEST_EXIT_DEV : test_exit_dev_token_i, test_exit_dev_token_o);
    check_val(t.name, "dev_exit_prod_token",
              t.tok_en ? `SVC_TOK_DEV_EXIT_PROD : dev_exit_prod_token_i, dev_exit_prod_token_o);
    check_val(t.name, "prod_exit_prodend_token",
              t.tok_en ? `SVC_TOK_PROD_EXIT_PRODEND : prod_exit_prodend_token_i,
              prod_exit_prodend_token_o);
    check_val(t.name, "rma_token", t.tok_en ? `SVC_TOK_RMA : rma_token_i, rma_token_o);
    check_val(t.name, "test_tokens_valid",
              128'(t.tok_en ? `SVC_TOK_VALID_ON : test_tokens_valid_i), 128'(test_tokens_valid_o));
    check_val(t.name, "rma_token_valid",
              128'(t.tok_en ? `SVC_TOK_VALID_ON : rma_token_valid_i), 128'(rma_token_valid_o));
    check_val(t.name, "fc_lcc_rst_n", 128'(t.hold ? 1'b0 : fc_lcc_rst_ni_i),
              128'(fc_lcc_rst_no));
  endtask

  task automatic wait_reset_release(input string name);
    int waited;
    waited = 0;
    while (!fc_lcc_rst_no && waited < HOLD_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (!fc_lcc_rst_no) begin
      $display("timeout: controller reset in test %s was never released", name);
      test_ok   = 1'b0;
      timed_out = 1'b1;
    end else begin
      check_val(name, "reset_low_cycles", 128'(`SVC_RST_HOLD_CYCLES),
                128'(low_total - start_total));
    end
  endtask

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------
  initial begin
    clk             = 1'b0;
    cptra_rst_b     = 1'b0;
    svc_cmd_valid_i = 1'b0;
    svc_cmd_i       = '0;
    rng             = 32'd42;
    low_total       = 0;
    start_total     = 0;
    pass_cnt        = 0;
    fail_cnt        = 0;
    test_ok         = 1'b1;
    timed_out       = 1'b0;
    draw_inputs(1'b1);

    // Expected override state is cumulative over the entries
    add_test("idle", CMD_NONE, CMD_NONE, 32'h0, 7'b0000000);
    add_test("unknown_code", 8'h3c, CMD_NONE, 32'h0, 7'b1000000);
    add_test("aw_core", `SVC_CMD_FORCE_AWUSER_CORE, CMD_NONE, `SVC_AWUSER_CORE, 7'b1100000);
    add_test("aw_mcu", `SVC_CMD_FORCE_AWUSER_MCU, CMD_NONE, `SVC_AWUSER_MCU, 7'b1100000);
    add_test("aw_release", `SVC_CMD_RELEASE_AWUSER, CMD_NONE, 32'h0, 7'b1000000);
    add_test("zero_set", `SVC_CMD_FORCE_ZEROIZATION, CMD_NONE, 32'h0, 7'b1011000);
    add_test("zero_clr", `SVC_CMD_FORCE_ZEROIZATION_RST, CMD_NONE, 32'h0, 7'b1010000);
    add_test("zero_release", `SVC_CMD_RELEASE_ZEROIZATION, CMD_NONE, 32'h0, 7'b1000000);
    add_test("lc_tokens", `SVC_CMD_FORCE_LC_TOKENS, CMD_NONE, 32'h0, 7'b1000100);
    add_test("rma_scrap_ppd", `SVC_CMD_FORCE_RMA_SCRAP_PPD, CMD_NONE, 32'h0, 7'b1000110);
    add_test("persist", `SVC_CMD_FORCE_AWUSER_CORE, CMD_NONE, `SVC_AWUSER_CORE, 7'b1100110);
    add_test("fc_lcc_reset", `SVC_CMD_FC_LCC_RESET, CMD_NONE, `SVC_AWUSER_CORE, 7'b1100111);
    add_test("reset_retrigger", `SVC_CMD_FC_LCC_RESET, `SVC_CMD_FC_LCC_RESET,
             `SVC_AWUSER_CORE, 7'b1100111);
    add_test("back_to_back", `SVC_CMD_FORCE_AWUSER_MCU, `SVC_CMD_FORCE_ZEROIZATION,
             `SVC_AWUSER_MCU, 7'b1111110);
    add_test("back_to_back_rel", `SVC_CMD_RELEASE_AWUSER, `SVC_CMD_RELEASE_ZEROIZATION,
             32'h0, 7'b1000110);

    repeat (8) @(negedge clk);
    cptra_rst_b = 1'b1;

    // A controller reset that never releases stops the run
    for (int i = 0; i < tests.size() && !timed_out; i++) begin
      test_ok = 1'b1;
      draw_inputs(tests[i].hold);
      start_total = low_total;
      send_cmd(tests[i]);
      check_outputs(tests[i]);
      if (tests[i].hold) begin
        wait_reset_release(tests[i].name);
      end
      if (test_ok) begin
        pass_cnt++;
      end else begin
        fail_cnt++;
      end
      $display("test %0d %s: %s", i, tests[i].name, test_ok ? "passed" : "FAILED");
    end

    $display("%0d tests, %0d passed, %0d failed", tests.size(), pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: source/svc_top.sv
// Top level of the service override block, stage instances and wiring
`timescale 1ns/1ns
`default_nettype none

module svc_top (
  input  logic               clk,
  input  logic               cptra_rst_b,
  input  logic               svc_cmd_valid_i,
  input  svc_pkg::svc_cmd_t  svc_cmd_i,
  input  svc_pkg::awuser_t   awuser_i,
  input  logic               fips_zero_ppd_i,
  input  svc_pkg::rom_mask_t rom_zero_mask_i,
  input  logic               lcc_scrap_mode_i,
  input  logic               allow_rma_scrap_ppd_i,
  input  svc_pkg::lc_token_t test_unlock_token_i,
  input  svc_pkg::lc_token_t test_exit_dev_token_i,
  input  svc_pkg::lc_token_t dev_exit_prod_token_i,
  input  svc_pkg::lc_token_t prod_exit_prodend_token_i,
  input  svc_pkg::lc_token_t rma_token_i,
  input  svc_pkg::lc_tx_t    test_tokens_valid_i,
  input  svc_pkg::lc_tx_t    rma_token_valid_i,
  input  logic               fc_lcc_rst_ni_i,
  output svc_pkg::awuser_t   awuser_o,
  output logic               fips_zero_ppd_o,
  output svc_pkg::rom_mask_t rom_zero_mask_o,
  output logic               lcc_scrap_mode_o,
  output logic               allow_rma_scrap_ppd_o,
  output svc_pkg::lc_token_t test_unlock_token_o,
  output svc_pkg::lc_token_t test_exit_dev_token_o,
  output svc_pkg::lc_token_t dev_exit_prod_token_o,
  output svc_pkg::lc_token_t prod_exit_prodend_token_o,
  output svc_pkg::lc_token_t rma_token_o,
  output svc_pkg::lc_tx_t    test_tokens_valid_o,
  output svc_pkg::lc_tx_t    rma_token_valid_o,
  output logic               fc_lcc_rst_no
);
  import svc_pkg::*;

  // Action pulses from decode
  logic act_awuser_core;
  logic act_awuser_mcu;
  logic act_awuser_rel;
  logic act_zero_set;
  logic act_zero_clr;
  logic act_zero_rel;
  logic act_tokens;
  logic act_ppd;
  logic act_rst;

  // Override state toward the multiplexer
  logic    awuser_ovr_en;
  awuser_t awuser_ovr;
  logic    zero_ovr_en;
  logic    zero_level;
  logic    tok_ovr_en;
  logic    ppd_ovr_en;
  logic    rst_hold;

  svc_cmd_decode u_cmd_decode (
    .clk               (clk),
    .cptra_rst_b       (cptra_rst_b),
    .svc_cmd_valid_i   (svc_cmd_valid_i),
    .svc_cmd_i         (svc_cmd_i),
    .act_awuser_core_o (act_awuser_core),
    .act_awuser_mcu_o  (act_awuser_mcu),
    .act_awuser_rel_o  (act_awuser_rel),
    .act_zero_set_o    (act_zero_set),
    .act_zero_clr_o    (act_zero_clr),
    .act_zero_rel_o    (act_zero_rel),
    .act_tokens_o      (act_tokens),
    .act_ppd_o         (act_ppd),
    .act_rst_o         (act_rst)
  );

  svc_override_regs u_override_regs (
    .clk               (clk),
    .cptra_rst_b       (cptra_rst_b),
    .act_awuser_core_i (act_awuser_core),
    .act_awuser_mcu_i  (act_awuser_mcu),
    .act_awuser_rel_i  (act_awuser_rel),
    .act_zero_set_i    (act_zero_set),
    .act_zero_clr_i    (act_zero_clr),
    .act_zero_rel_i    (act_zero_rel),
    .act_tokens_i      (act_tokens),
    .act_ppd_i         (act_ppd),
    .awuser_ovr_en_o   (awuser_ovr_en),
    .awuser_ovr_o      (awuser_ovr),
    .zero_ovr_en_o     (zero_ovr_en),
    .zero_level_o      (zero_level),
    .tok_ovr_en_o      (tok_ovr_en),
    .ppd_ovr_en_o      (ppd_ovr_en)
  );

  svc_reset_seq u_reset_seq (
    .clk         (clk),
    .cptra_rst_b (cptra_rst_b),
    .act_rst_i   (act_rst),
    .rst_hold_o  (rst_hold)
  );

  svc_signal_mux u_signal_mux (
    .awuser_ovr_en_i           (awuser_ovr_en),
    .awuser_ovr_i              (awuser_ovr),
    .zero_ovr_en_i             (zero_ovr_en),
    .zero_level_i              (zero_level),
    .tok_ovr_en_i              (tok_ovr_en),
    .ppd_ovr_en_i              (ppd_ovr_en),
    .rst_hold_i                (rst_hold),
    .awuser_i                  (awuser_i),
    .fips_zero_ppd_i           (fips_zero_ppd_i),
    .rom_zero_mask_i           (rom_zero_mask_i),
    .lcc_scrap_mode_i          (lcc_scrap_mode_i),
    .allow_rma_scrap_ppd_i     (allow_rma_scrap_ppd_i),
    .test_unlock_token_i       (test_unlock_token_i),
    .test_exit_dev_token_i     (test_exit_dev_token_i),
    .dev_exit_prod_token_i     (dev_exit_prod_token_i),
    .prod_exit_prodend_token_i (prod_exit_prodend_token_i),
    .rma_token_i               (rma_token_i),
    .test_tokens_valid_i       (test_tokens_valid_i),
    .rma_token_valid_i         (rma_token_valid_i),
    .fc_lcc_rst_ni_i           (fc_lcc_rst_ni_i),
    .awuser_o                  (awuser_o),
    .fips_zero_ppd_o           (fips_zero_ppd_o),
    .rom_zero_mask_o           (rom_zero_mask_o),
    .lcc_scrap_mode_o          (lcc_scrap_mode_o),
    .allow_rma_scrap_ppd_o     (allow_rma_scrap_ppd_o),
    .test_unlock_token_o       (test_unlock_token_o),
    .test_exit_dev_token_o     (test_exit_dev_token_o),
    .dev_exit_prod_token_o     (dev_exit_prod_token_o),
    .prod_exit_prodend_token_o (prod_exit_prodend_token_o),
    .rma_token_o               (rma_token_o),
    .test_tokens_valid_o       (test_tokens_valid_o),
    .rma_token_valid_o         (rma_token_valid_o),
    .fc_lcc_rst_no             (fc_lcc_rst_no)
  );

endmodule

`default_nettype wire

// File: source/svc_signal_mux.sv
// Output stage, override multiplexers for every controlled signal
`timescale 1ns/1ns
`default_nettype none
`include "svc_defs.svh"

module svc_signal_mux (
  // Override state
  input  logic               awuser_ovr_en_i,
  input  svc_pkg::awuser_t   awuser_ovr_i,
  input  logic               zero_ovr_en_i,
  input  logic               zero_level_i,
  input  logic               tok_ovr_en_i,
  input  logic               ppd_ovr_en_i,
  input  logic               rst_hold_i,
  // Functional inputs
  input  svc_pkg::awuser_t   awuser_i,
  input  logic               fips_zero_ppd_i,
  input  svc_pkg::rom_mask_t rom_zero_mask_i,
  input  logic               lcc_scrap_mode_i,
  input  logic               allow_rma_scrap_ppd_i,
  input  svc_pkg::lc_token_t test_unlock_token_i,
  input  svc_pkg::lc_token_t test_exit_dev_token_i,
  input  svc_pkg::lc_token_t dev_exit_prod_token_i,
  input  svc_pkg::lc_token_t prod_exit_prodend_token_i,
  input  svc_pkg::lc_token_t rma_token_i,
  input  svc_pkg::lc_tx_t    test_tokens_valid_i,
  input  svc_pkg::lc_tx_t    rma_token_valid_i,
  input  logic               fc_lcc_rst_ni_i,
  // Signals toward the fuse and life-cycle controllers
  output svc_pkg::awuser_t   awuser_o,
  output logic               fips_zero_ppd_o,
  output svc_pkg::rom_mask_t rom_zero_mask_o,
  output logic               lcc_scrap_mode_o,
  output logic               allow_rma_scrap_ppd_o,
  output svc_pkg::lc_token_t test_unlock_token_o,
  output svc_pkg::lc_token_t test_exit_dev_token_o,
  output svc_pkg::lc_token_t dev_exit_prod_token_o,
  output svc_pkg::lc_token_t prod_exit_prodend_token_o,
  output svc_pkg::lc_token_t rma_token_o,
  output svc_pkg::lc_tx_t    test_tokens_valid_o,
  output svc_pkg::lc_tx_t    rma_token_valid_o,
  output logic               fc_lcc_rst_no
);

  assign awuser_o = awuser_ovr_en_i ? awuser_ovr_i : awuser_i;

  // ----------------------------------------------------------------------
  // Zeroization group
  // ----------------------------------------------------------------------
  // Scrap mode is driven to the opposite of the PPD pin in both patterns
  assign fips_zero_ppd_o  = zero_ovr_en_i ? zero_level_i : fips_zero_ppd_i;
  assign lcc_scrap_mode_o = zero_ovr_en_i ? !zero_level_i : lcc_scrap_mode_i;
  assign rom_zero_mask_o  = !zero_ovr_en_i ? rom_zero_mask_i :
                            zero_level_i ? `SVC_ZERO_MASK_ALL : '0;

  assign allow_rma_scrap_ppd_o = ppd_ovr_en_i ? 1'b1 : allow_rma_scrap_ppd_i;

  // ----------------------------------------------------------------------
  // OTP token bundle
  // ----------------------------------------------------------------------
  assign test_unlock_token_o = tok_ovr_en_i ? `SVC_TOK_TEST_UNLOCK : test_unlock_token_i;
  assign test_exit_dev_token_o = tok_ovr_en_i ? `SVC_TOK_TEST_EXIT_DEV : test_exit_dev_token_i;
  assign dev_exit_prod_token_o = tok_ovr_en_i ? `SVC_TOK_DEV_EXIT_PROD : dev_exit_prod_token_i;
  assign prod_exit_prodend_token_o = tok_ovr_en_i ? `SVC_TOK_PROD_EXIT_PRODEND :
                                                    prod_exit_prodend_token_i;
  assign rma_token_o         = tok_ovr_en_i ? `SVC_TOK_RMA : rma_token_i;
  assign test_tokens_valid_o = tok_ovr_en_i ? `SVC_TOK_VALID_ON : test_tokens_valid_i;
  assign rma_token_valid_o   = tok_ovr_en_i ? `SVC_TOK_VALID_ON : rma_token_valid_i;

  // Either source can pull the controllers into reset
  assign fc_lcc_rst_no = fc_lcc_rst_ni_i && !rst_hold_i;

endmodule

`default_nettype wire

// File: source/svc_reset_seq.sv
// Reset stage, FSM holding the controller reset low for a fixed count
`timescale 1ns/1ns
`default_nettype none
`include "svc_defs.svh"

module svc_reset_seq (
  input  logic clk,
  input  logic cptra_rst_b,
  input  logic act_rst_i,
  output logic rst_hold_o
);
  import svc_pkg::*;

  rst_seq_e   state_q;
  logic [3:0] cnt_q;

  // A request during HOLD is ignored and the count runs on unchanged
  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (act_rst_i) begin
            state_q <= HOLD;
            cnt_q   <= '0;
          end
        end
        HOLD: begin
          // Last HOLD cycle has the counter at hold length minus one
          if (cnt_q == 4'(`SVC_RST_HOLD_CYCLES - 1)) begin
            state_q <= IDLE;
          end else begin
            cnt_q <= cnt_q + 4'd1;
          end
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  assign rst_hold_o = (state_q == HOLD);

endmodule

`default_nettype wire

// File: source/svc_override_regs.sv
// Override state stage with sticky enables and override values
`timescale 1ns/1ns
`default_nettype none
`include "svc_defs.svh"

module svc_override_regs (
  input  logic             clk,
  input  logic             cptra_rst_b,
  input  logic             act_awuser_core_i,
  input  logic             act_awuser_mcu_i,
  input  logic             act_awuser_rel_i,
  input  logic             act_zero_set_i,
  input  logic             act_zero_clr_i,
  input  logic             act_zero_rel_i,
  input  logic             act_tokens_i,
  input  logic             act_ppd_i,
  output logic             awuser_ovr_en_o,
  output svc_pkg::awuser_t awuser_ovr_o,
  output logic             zero_ovr_en_o,
  output logic             zero_level_o,
  output logic             tok_ovr_en_o,
  output logic             ppd_ovr_en_o
);

  // ----------------------------------------------------------------------
  // Enables
  // ----------------------------------------------------------------------
  // Token and PPD overrides have no release, only reset clears them
  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      awuser_ovr_en_o <= 1'b0;
      zero_ovr_en_o   <= 1'b0;
      tok_ovr_en_o    <= 1'b0;
      ppd_ovr_en_o    <= 1'b0;
    end else begin
      if (act_awuser_core_i || act_awuser_mcu_i) begin
        awuser_ovr_en_o <= 1'b1;
      end else if (act_awuser_rel_i) begin
        awuser_ovr_en_o <= 1'b0;
      end

      if (act_zero_set_i || act_zero_clr_i) begin
        zero_ovr_en_o <= 1'b1;
      end else if (act_zero_rel_i) begin
        zero_ovr_en_o <= 1'b0;
      end

      if (act_tokens_i) begin
        tok_ovr_en_o <= 1'b1;
      end

      if (act_ppd_i) begin
        ppd_ovr_en_o <= 1'b1;
      end
    end
  end

  // ----------------------------------------------------------------------
  // Override values
  // ----------------------------------------------------------------------
  // Values are only looked at while their enable is set
  always_ff @(posedge clk) begin
    if (act_awuser_core_i) begin
      awuser_ovr_o <= `SVC_AWUSER_CORE;
    end else if (act_awuser_mcu_i) begin
      awuser_ovr_o <= `SVC_AWUSER_MCU;
    end

    // Level 1 is the zeroization pattern, level 0 the zeroization reset pattern
    if (act_zero_set_i) begin
      zero_level_o <= 1'b1;
    end else if (act_zero_clr_i) begin
      zero_level_o <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: source/svc_cmd_decode.sv
// Command capture stage, registers the strobe and decodes it into action pulses
`timescale 1ns/1ns
`default_nettype none
`include "svc_defs.svh"

module svc_cmd_decode (
  input  logic              clk,
  input  logic              cptra_rst_b,
  input  logic              svc_cmd_valid_i,
  input  svc_pkg::svc_cmd_t svc_cmd_i,
  output logic              act_awuser_core_o,
  output logic              act_awuser_mcu_o,
  output logic              act_awuser_rel_o,
  output logic              act_zero_set_o,
  output logic              act_zero_clr_o,
  output logic              act_zero_rel_o,
  output logic              act_tokens_o,
  output logic              act_ppd_o,
  output logic              act_rst_o
);
  import svc_pkg::*;

  logic     cmd_valid_q;
  svc_cmd_t cmd_q;

  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      cmd_valid_q <= 1'b0;
    end else begin
      cmd_valid_q <= svc_cmd_valid_i;
    end
  end

  // Command byte only matters while cmd_valid_q is set
  always_ff @(posedge clk) begin
    if (svc_cmd_valid_i) begin
      cmd_q <= svc_cmd_i;
    end
  end

  // One pulse per recognized code, for the cycle after the sampling edge
  always_comb begin
    act_awuser_core_o = 1'b0;
    act_awuser_mcu_o  = 1'b0;
    act_awuser_rel_o  = 1'b0;
    act_zero_set_o    = 1'b0;
    act_zero_clr_o    = 1'b0;
    act_zero_rel_o    = 1'b0;
    act_tokens_o      = 1'b0;
    act_ppd_o         = 1'b0;
    act_rst_o         = 1'b0;
    if (cmd_valid_q) begin
      case (cmd_q)
        `SVC_CMD_FORCE_AWUSER_CORE:     act_awuser_core_o = 1'b1;
        `SVC_CMD_FORCE_AWUSER_MCU:      act_awuser_mcu_o  = 1'b1;
        `SVC_CMD_RELEASE_AWUSER:        act_awuser_rel_o  = 1'b1;
        `SVC_CMD_FORCE_ZEROIZATION:     act_zero_set_o    = 1'b1;
        `SVC_CMD_FORCE_ZEROIZATION_RST: act_zero_clr_o    = 1'b1;
        `SVC_CMD_RELEASE_ZEROIZATION:   act_zero_rel_o    = 1'b1;
        `SVC_CMD_FORCE_LC_TOKENS:       act_tokens_o      = 1'b1;
        `SVC_CMD_FORCE_RMA_SCRAP_PPD:   act_ppd_o         = 1'b1;
        `SVC_CMD_FC_LCC_RESET:          act_rst_o         = 1'b1;
        default: begin
          // Unknown codes are dropped
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: source/svc_pkg.sv
// Vector typedefs and reset sequencer state enum for the service block
`default_nettype none

package svc_pkg;

  // Service command byte
  typedef logic [7:0] svc_cmd_t;

  // AXI write user field toward the fuse controller
  typedef logic [31:0] awuser_t;

  // MCU ROM zeroization mask
  typedef logic [31:0] rom_mask_t;

  // One life-cycle token from OTP
  typedef logic [127:0] lc_token_t;

  // Multibit life-cycle boolean
  typedef logic [3:0] lc_tx_t;

  // Controller reset sequencer
  typedef enum logic {
    IDLE,
    HOLD
  } rst_seq_e;

endpackage

`default_nettype wire

// File: source/svc_defs.svh
// Command codes, reset hold length, strap values, zeroization mask and test token constants
`ifndef SVC_DEFS_SVH
`define SVC_DEFS_SVH

// ----------------------------------------------------------------------
// Service command codes
// ----------------------------------------------------------------------
`define SVC_CMD_FORCE_AWUSER_CORE      8'h01
`define SVC_CMD_FORCE_AWUSER_MCU       8'h02
`define SVC_CMD_RELEASE_AWUSER         8'h03
`define SVC_CMD_FORCE_ZEROIZATION      8'h04
`define SVC_CMD_FORCE_ZEROIZATION_RST  8'h05
`define SVC_CMD_RELEASE_ZEROIZATION    8'h06
`define SVC_CMD_FORCE_LC_TOKENS        8'h07
`define SVC_CMD_FORCE_RMA_SCRAP_PPD    8'h08
`define SVC_CMD_FC_LCC_RESET           8'h10

// ----------------------------------------------------------------------
// Controller reset sequencing
// ----------------------------------------------------------------------
// Number of cycles fc_lcc_rst_no stays low, must fit the 4-bit counter
`define SVC_RST_HOLD_CYCLES 11

// ----------------------------------------------------------------------
// Override values
// ----------------------------------------------------------------------
// Strap AXI user values of the core and the MCU load/store unit
`define SVC_AWUSER_CORE   32'h0000_0001
`define SVC_AWUSER_MCU    32'h0000_0002

`define SVC_ZERO_MASK_ALL 32'hFFFF_FFFF

// Fixed life-cycle test tokens as seen on the OTP data bundle
`define SVC_TOK_TEST_UNLOCK       128'h3852_305b_aecf_5ff1_d5c1_d25f_6db9_058d
`define SVC_TOK_TEST_EXIT_DEV     128'hd10c_eca9_7253_73ec_32ac_874c_7381_bd54
`define SVC_TOK_DEV_EXIT_PROD     128'hf1c0_bd8a_da70_5018_5d36_67f5_aeeb_c767
`define SVC_TOK_PROD_EXIT_PRODEND 128'hdb17_c6f2_fa63_d690_734a_8a31_6147_d7e5
`define SVC_TOK_RMA               128'h6792_6115_6880_f4cc_5178_5553_16c5_1e4d

// Multibit life-cycle "On" encoding for the token valid flags
`define SVC_TOK_VALID_ON 4'b0101

`endif
